/* Bender.yml */
package:
  name: valu

sources:
  # Design, in compile order
  - design/valu_pkg.sv
  - design/valu_lane.sv
  - design/valu_decode.sv
  - design/valu_execute.sv
  - design/valu_writeback.sv
  - design/valu_top.sv

  # Testbench and bound checker
  - target: simulation
    files:
      - dv/valu_checker.sv
      - dv/valu_tb.sv

/* design/valu_decode.sv */
// ------------------------------
// Decode stage: Wishbone request acceptance,
// command to lane control translation and operand registers
// ------------------------------
`default_nettype none

module valu_decode import valu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       wb_cyc,
    input  wire logic       wb_stb,
    input  wire alu_req_t   wb_req,
    input  wire logic       wb_ack,
    output logic            dec_valid,
    output lane_ctrl_t      dec_ctrl,
    output lane_vec_t       dec_op1,
    output lane_vec_t       dec_op2
);

    logic       in_flight;  // One request inside the pipeline
    logic       accept;
    lane_ctrl_t ctrl_next;

    assign accept = wb_cyc & wb_stb & ~in_flight;

    // ------------------------------
    // Command translation
    // ------------------------------
    always_comb begin
        ctrl_next = '{sub: 1'b0, sel: sel_zero, cond: cond_lt, shift: shift_ll};
        case (wb_req.cmd)
            cmd_and  : ctrl_next.sel = sel_and;
            cmd_or   : ctrl_next.sel = sel_or;
            cmd_xor  : ctrl_next.sel = sel_xor;
            cmd_add  : ctrl_next.sel = sel_sum;
            cmd_sub  : ctrl_next = '{sub: 1'b1, sel: sel_sum, cond: cond_lt, shift: shift_ll};
            cmd_slt  : ctrl_next = '{sub: 1'b1, sel: sel_cond, cond: cond_lt, shift: shift_ll};
            cmd_sltu : ctrl_next = '{sub: 1'b1, sel: sel_cond, cond: cond_ltu, shift: shift_ll};
            cmd_eq   : ctrl_next = '{sub: 1'b1, sel: sel_cond, cond: cond_eq, shift: shift_ll};
            cmd_ne   : ctrl_next = '{sub: 1'b1, sel: sel_cond, cond: cond_ne, shift: shift_ll};
            cmd_ge   : ctrl_next = '{sub: 1'b1, sel: sel_cond, cond: cond_ge, shift: shift_ll};
            cmd_geu  : ctrl_next = '{sub: 1'b1, sel: sel_cond, cond: cond_geu, shift: shift_ll};
            cmd_sll  : ctrl_next.sel = sel_shift;
            cmd_srl  : ctrl_next = '{sub: 1'b0, sel: sel_shift, cond: cond_lt, shift: shift_rl};
            cmd_sra  : ctrl_next = '{sub: 1'b0, sel: sel_shift, cond: cond_lt, shift: shift_ra};
            default  : ctrl_next.sel = sel_zero;  // Illegal code gives zeros
        endcase
    end

    // In-flight flag clears on the acknowledge edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
            if (accept) begin
                in_flight <= 1'b1;
            end else if (wb_ack) begin
                in_flight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_ctrl <= ctrl_next;
            dec_op1  <= wb_req.op1;
            dec_op2  <= wb_req.op2;
        end
    end

endmodule

`default_nettype wire

/* design/valu_execute.sv */
// ------------------------------
// Execute stage: lane array and result registers
// with the lane 0 compare flag
// ------------------------------
`default_nettype none

module valu_execute import valu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       dec_valid,
    input  wire lane_ctrl_t dec_ctrl,
    input  wire lane_vec_t  dec_op1,
    input  wire lane_vec_t  dec_op2,
    output logic            exe_valid,
    output alu_rsp_t        exe_rsp
);

    lane_vec_t          lane_res;
    logic [lanes-1:0]   lane_hit;  // Condition result of every lane
    logic               cmp_next;

    // ------------------------------
    // Lane array
    // ------------------------------
    for (genvar g = 0; g < lanes; g++) begin : g_lane
        valu_lane u_lane (
            .ctrl     (dec_ctrl),
            .op1      (dec_op1[g]),
            .op2      (dec_op2[g]),
            .res      (lane_res[g]),
            .cond_hit (lane_hit[g])
        );
    end

    // Compare flag only for comparison commands
    assign cmp_next = (dec_ctrl.sel == sel_cond) & lane_hit[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_rsp.res <= lane_res;
            exe_rsp.cmp <= cmp_next;
        end
    end

endmodule

`default_nettype wire

/* design/valu_lane.sv */
// ------------------------------
// Single lane datapath: adder with flags,
// shifter, logic unit, condition and result select
// ------------------------------
`default_nettype none

module valu_lane import valu_pkg::*; (
    input  wire lane_ctrl_t         ctrl,
    input  wire logic [xlen-1:0]    op1,
    input  wire logic [xlen-1:0]    op2,
    output logic [xlen-1:0]         res,
    output logic                    cond_hit
);

    logic [xlen:0]      sum_full;   // Extra bit holds carry or borrow
    logic               op2_msb;    // Sign of the effective second operand
    alu_flags_t         flags;
    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0]    shift_res;

    // ------------------------------
    // Adder and flags
    // ------------------------------
    always_comb begin
        if (ctrl.sub) begin
            sum_full = {1'b0, op1} - {1'b0, op2};
        end else begin
            sum_full = {1'b0, op1} + {1'b0, op2};
        end
    end

    assign op2_msb = op2[xlen-1] ^ ctrl.sub;

    always_comb begin
        flags.z = ~|sum_full[xlen-1:0];
        flags.s = sum_full[xlen-1];
        // Operands agree in sign but the result does not
        flags.o = (op1[xlen-1] == op2_msb) & (sum_full[xlen-1] != op1[xlen-1]);
        flags.c = sum_full[xlen];
    end

    // ------------------------------
    // Shifter
    // ------------------------------
    assign shamt = op2[shamt_w-1:0];  // Upper bits of op2 ignored

    always_comb begin
        case (ctrl.shift)
            shift_rl : shift_res = op1 >> shamt;
            shift_ra : shift_res = $signed(op1) >>> shamt;  // Sign fill
            default  : shift_res = op1 << shamt;
        endcase
    end

    // Comparison rule
    always_comb begin
        case (ctrl.cond)
            cond_lt  : cond_hit = flags.s ^ flags.o;
            cond_ltu : cond_hit = flags.c;
            cond_eq  : cond_hit = flags.z;
            cond_ne  : cond_hit = ~flags.z;
            cond_ge  : cond_hit = ~(flags.s ^ flags.o);
            cond_geu : cond_hit = ~flags.c;
            default  : cond_hit = 1'b0;
        endcase
    end

    // ------------------------------
    // Result select
    // ------------------------------
    always_comb begin
        case (ctrl.sel)
            sel_and   : res = op1 & op2;
            sel_or    : res = op1 | op2;
            sel_xor   : res = op1 ^ op2;
            sel_sum   : res = sum_full[xlen-1:0];
            sel_cond  : res = {{(xlen-1){1'b0}}, cond_hit};  // Zero-extended flag
            sel_shift : res = shift_res;
            default   : res = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/valu_pkg.sv */
// ------------------------------
// Shared widths, lane count, command and control enums,
// flag struct and the request and response structs of the vector ALU
// ------------------------------
`default_nettype none

package valu_pkg;

    localparam int xlen    = 32;  // Lane width
    localparam int lanes   = 4;   // Number of lanes
    localparam int shamt_w = 5;   // Shift amount width

    typedef logic [lanes-1:0][xlen-1:0] lane_vec_t;

    // Command codes, 14 and 15 are illegal
    typedef enum logic [3:0] {
        cmd_and, cmd_or, cmd_xor,
        cmd_add, cmd_sub,
        cmd_slt, cmd_sltu, cmd_eq, cmd_ne, cmd_ge, cmd_geu,
        cmd_sll, cmd_srl, cmd_sra
    } alu_cmd_e;

    typedef enum logic [2:0] {
        sel_and, sel_or, sel_xor, sel_sum, sel_cond, sel_shift, sel_zero
    } res_sel_e;

    typedef enum logic [2:0] {
        cond_lt, cond_ltu, cond_eq, cond_ne, cond_ge, cond_geu
    } cond_e;

    typedef enum logic [1:0] {
        shift_ll, shift_rl, shift_ra
    } shift_e;

    typedef struct packed {
        logic z;  // Zero
        logic s;  // Sign
        logic o;  // Signed overflow
        logic c;  // Carry or borrow out
    } alu_flags_t;

    // Per-lane control produced by the decode stage
    typedef struct packed {
        logic     sub;
        res_sel_e sel;
        cond_e    cond;
        shift_e   shift;
    } lane_ctrl_t;

    typedef struct packed {
        alu_cmd_e  cmd;
        lane_vec_t op1;
        lane_vec_t op2;
    } alu_req_t;

    typedef struct packed {
        lane_vec_t res;
        logic      cmp;  // Compare flag of lane 0
    } alu_rsp_t;

endpackage

`default_nettype wire

/* design/valu_top.sv */
// ------------------------------
// Vector ALU top level with Wishbone classic slave port
// ------------------------------
`default_nettype none

module valu_top import valu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       wb_cyc,
    input  wire logic       wb_stb,
    input  wire alu_req_t   wb_req,
    output logic            wb_ack,
    output alu_rsp_t        wb_rsp
);

    // ------------------------------
    // Stage interconnect
    // ------------------------------
    logic       dec_valid;
    lane_ctrl_t dec_ctrl;
    lane_vec_t  dec_op1;
    lane_vec_t  dec_op2;
    logic       exe_valid;
    alu_rsp_t   exe_rsp;

    valu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_req    (wb_req),
        .wb_ack    (wb_ack),     // Clears the in-flight flag
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl),
        .dec_op1   (dec_op1),
        .dec_op2   (dec_op2)
    );

    valu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl),
        .dec_op1   (dec_op1),
        .dec_op2   (dec_op2),
        .exe_valid (exe_valid),
        .exe_rsp   (exe_rsp)
    );

    valu_writeback u_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_valid (exe_valid),
        .exe_rsp   (exe_rsp),
        .wb_ack    (wb_ack),
        .wb_rsp    (wb_rsp)
    );

endmodule

`default_nettype wire

/* design/valu_writeback.sv */
// ------------------------------
// Writeback stage: response register
// and one-cycle Wishbone acknowledge
// ------------------------------
`default_nettype none

module valu_writeback import valu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       exe_valid,
    input  wire alu_rsp_t   exe_rsp,
    output logic            wb_ack,
    output alu_rsp_t        wb_rsp
);

    // One ack per item, the pipeline never holds two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= exe_valid;
        end
    end

    // Response holds its last value between acks
    always_ff @(posedge clk) begin
        if (exe_valid) begin
            wb_rsp <= exe_rsp;
        end
    end

endmodule

`default_nettype wire

/* dv/valu_checker.sv */
// ------------------------------
// Bound assertions on the Wishbone
// acknowledge and response of the vector ALU
// with a count of assertion failures
// ------------------------------
`default_nettype none

module valu_checker import valu_pkg::*; (
    input wire logic     clk,
    input wire logic     rst_n,
    input wire logic     wb_cyc,
    input wire logic     wb_stb,
    input wire logic     wb_ack,
    input wire alu_rsp_t wb_rsp
);

    timeunit 1ns;
    timeprecision 100ps;

    logic pending;   // Request taken and ack not yet seen
    logic accepted;
    int   assert_errors = 0;  // Failed assertions so far

    assign accepted = wb_cyc & wb_stb & ~pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (accepted) begin
            pending <= 1'b1;
        end else if (wb_ack) begin
            pending <= 1'b0;
        end
    end

    // ------------------------------
    // Handshake and response
    // ------------------------------
    a_ack_single : assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack high in two consecutive cycles");
            assert_errors++;
        end

    a_ack_latency : assert property (@(posedge clk) disable iff (!rst_n)
        accepted |=> !wb_ack ##1 !wb_ack ##1 wb_ack)
        else begin
            $error("wb_ack not 3 cycles after an accepted request");
            assert_errors++;
        end

    a_rsp_known : assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> !$isunknown(wb_rsp))
        else begin
            $error("wb_rsp has unknown bits during wb_ack");
            assert_errors++;
        end

    a_ack_reset : assert property (@(posedge clk) !rst_n |-> !wb_ack)
        else begin
            $error("wb_ack high during reset");
            assert_errors++;
        end

endmodule

bind valu_top valu_checker u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .wb_rsp (wb_rsp)
);

`default_nettype wire

/* dv/valu_tb.sv */
// ------------------------------
// Vector ALU testbench with clock, reset, directed table,
// random requests, reference model and error counts
// ------------------------------
`default_nettype none

module valu_tb
    import valu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ack_timeout = 20;  // Cycles allowed per acknowledge
    localparam int latency     = 3;

    logic     clk;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    alu_req_t wb_req;
    logic     wb_ack;
    alu_rsp_t wb_rsp;

    integer   seed;
    int       checks;
    int       value_errors;
    int       timeout_errors;

    // Directed table with one entry per index
    string      tc_name[$];
    logic [3:0] tc_cmd[$];
    lane_vec_t  tc_op1[$];
    lane_vec_t  tc_op2[$];
    lane_vec_t  tc_res[$];
    logic       tc_cmp[$];

    valu_top dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_req (wb_req),
        .wb_ack (wb_ack),
        .wb_rsp (wb_rsp)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [xlen-1:0] lane_result(input logic [3:0] code,
                                                     input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b);
        logic [shamt_w-1:0]     sh;
        logic signed [xlen-1:0] sa;
        sh = b[shamt_w-1:0];  // Only the low bits count
        sa = a;
        case (code)
            cmd_and  : return a & b;
            cmd_or   : return a | b;
            cmd_xor  : return a ^ b;
            cmd_add  : return a + b;
            cmd_sub  : return a - b;
            cmd_slt  : return xlen'($signed(a) < $signed(b));
            cmd_sltu : return xlen'(a < b);
            cmd_eq   : return xlen'(a == b);
            cmd_ne   : return xlen'(a != b);
            cmd_ge   : return xlen'($signed(a) >= $signed(b));
            cmd_geu  : return xlen'(a >= b);
            cmd_sll  : return a << sh;
            cmd_srl  : return a >> sh;
            cmd_sra  : return sa >>> sh;
            default  : return '0;  // Illegal codes
        endcase
    endfunction

    function automatic logic compare_flag(input logic [3:0] code,
                                          input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        logic [xlen-1:0] r;
        r = lane_result(code, a, b);
        if (code inside {cmd_slt, cmd_sltu, cmd_eq, cmd_ne, cmd_ge, cmd_geu}) begin
            return r[0];
        end
        return 1'b0;
    endfunction

    // ------------------------------
    // Checks and transactions
    // ------------------------------
    task automatic check_vector(input string what, input lane_vec_t expected,
                                input lane_vec_t actual);
        checks++;
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic expect_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h", what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic add_case(input string name, input logic [3:0] code, input lane_vec_t a,
                            input lane_vec_t b, input lane_vec_t r, input logic c);
        tc_name.push_back(name);
        tc_cmd.push_back(code);
        tc_op1.push_back(a);
        tc_op2.push_back(b);
        tc_res.push_back(r);
        tc_cmp.push_back(c);
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic run_request(input string name, input logic [3:0] code,
                               input lane_vec_t a, input lane_vec_t b,
                               input lane_vec_t exp_res, input logic exp_cmp);
        int       cycles;
        logic     seen;
        alu_rsp_t rsp;
        cycles     = 0;
        seen       = 1'b0;
        wb_req.cmd = alu_cmd_e'(code);
        wb_req.op1 = a;
        wb_req.op2 = b;
        wb_cyc     = 1'b1;
        wb_stb     = 1'b1;
        while (!seen && cycles < ack_timeout) begin
            @(posedge clk);
            #2;
            cycles++;
            seen = (wb_ack === 1'b1);
        end
        if (!seen) begin
            $display("Timeout: %s got no acknowledge within %0d cycles", name, ack_timeout);
            timeout_errors++;
        end else begin
            rsp = wb_rsp;
            @(posedge clk);  // Strobe held through the ack edge
            #2;
            check_vector({name, " res"}, exp_res, rsp.res);
            expect_value({name, " cmp"}, exp_cmp, rsp.cmp);
            expect_value({name, " latency"}, latency, cycles);
            expect_value({name, " single ack"}, 0, wb_ack);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic count_idle_acks(input int n_cycles);
        int acks;
        acks = 0;
        repeat (n_cycles) begin
            @(posedge clk);
            #2;
            if (wb_ack !== 1'b0) begin
                acks++;
            end
        end
        expect_value("idle acks", 0, acks);
    endtask

    // Vectors list lane 3 first
    task automatic build_table();
        lane_vec_t la;
        lane_vec_t lb;
        lane_vec_t ca;
        lane_vec_t cb;
        lane_vec_t sa;
        lane_vec_t sb;
        la = {32'hFFFF0000, 32'h12345678, 32'hF0F0F0F0, 32'hAAAAAAAA};
        lb = {32'h0F0F0F0F, 32'hFFFFFFFF, 32'h00FF00FF, 32'h55555555};
        ca = {32'h00000003, 32'hFFFFFFFF, 32'h00000005, 32'h80000000};
        cb = {32'h00000009, 32'h00000000, 32'h00000005, 32'h00000001};
        sa = {32'h80000000, 32'h7FFFFFF0, 32'h80000000, 32'hF0000000};
        sb = {32'h0000001F, 32'h00000004, 32'h00000000, 32'h00000021};  // 33 acts as 1
        add_case("and", cmd_and, la, lb,
                 {32'h0F0F0000, 32'h12345678, 32'h00F000F0, 32'h00000000}, 1'b0);
        add_case("or", cmd_or, la, lb,
                 {32'hFFFF0F0F, 32'hFFFFFFFF, 32'hF0FFF0FF, 32'hFFFFFFFF}, 1'b0);
        add_case("xor", cmd_xor, la, lb,
                 {32'hF0F00F0F, 32'hEDCBA987, 32'hF00FF00F, 32'hFFFFFFFF}, 1'b0);
        add_case("add_wrap", cmd_add,
                 {32'hFFFFFFFF, 32'h7FFFFFFF, 32'h00000001, 32'h12345678},
                 {32'h00000001, 32'h00000001, 32'hFFFFFFFF, 32'h11111111},
                 {32'h00000000, 32'h80000000, 32'h00000000, 32'h23456789}, 1'b0);
        add_case("sub_wrap", cmd_sub,
                 {32'h00000000, 32'h80000000, 32'h00000005, 32'h00000064},
                 {32'h00000001, 32'h00000001, 32'h00000007, 32'h00000032},
                 {32'hFFFFFFFF, 32'h7FFFFFFF, 32'hFFFFFFFE, 32'h00000032}, 1'b0);
        add_case("slt", cmd_slt, ca, cb, {32'd1, 32'd1, 32'd0, 32'd1}, 1'b1);
        add_case("sltu", cmd_sltu, ca, cb, {32'd1, 32'd0, 32'd0, 32'd0}, 1'b0);
        add_case("eq", cmd_eq, ca, cb, {32'd0, 32'd0, 32'd1, 32'd0}, 1'b0);
        add_case("ne", cmd_ne, ca, cb, {32'd1, 32'd1, 32'd0, 32'd1}, 1'b1);
        add_case("ge", cmd_ge, ca, cb, {32'd0, 32'd0, 32'd1, 32'd0}, 1'b0);
        add_case("geu", cmd_geu, ca, cb, {32'd0, 32'd1, 32'd1, 32'd1}, 1'b1);
        add_case("slt_ovf", cmd_slt,
                 {32'h00000000, 32'h00000000, 32'hFFFFFFFE, 32'h00000001},
                 {32'h00000000, 32'h00000000, 32'hFFFFFFFF, 32'h80000000},
                 {32'd0, 32'd0, 32'd1, 32'd0}, 1'b0);
        add_case("sll", cmd_sll,
                 {32'h80000001, 32'h00000001, 32'h12345678, 32'h00000001},
                 {32'h00000001, 32'h0000001F, 32'h00000004, 32'h00000021},
                 {32'h00000002, 32'h80000000, 32'h23456780, 32'h00000002}, 1'b0);
        add_case("srl", cmd_srl, sa, sb,
                 {32'h00000001, 32'h07FFFFFF, 32'h80000000, 32'h78000000}, 1'b0);
        add_case("sra", cmd_sra, sa, sb,
                 {32'hFFFFFFFF, 32'h07FFFFFF, 32'h80000000, 32'hF8000000}, 1'b0);
        add_case("illegal_e", 4'hE, la, lb, '0, 1'b0);
        add_case("illegal_f", 4'hF, ca, cb, '0, 1'b0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [3:0]  code;
        lane_vec_t   a;
        lane_vec_t   b;
        lane_vec_t   exp_res;
        logic        exp_cmp;
        logic [31:0] pick;
        int          assert_fails;
        seed           = 8;
        checks         = 0;
        value_errors   = 0;
        timeout_errors = 0;
        rst_n          = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_req         = '0;
        repeat (2) @(posedge clk);
        #2;
        expect_value("ack in reset", 0, wb_ack);
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        expect_value("ack after reset", 0, wb_ack);

        build_table();
        foreach (tc_name[i]) begin
            run_request(tc_name[i], tc_cmd[i], tc_op1[i], tc_op2[i], tc_res[i], tc_cmp[i]);
        end
        count_idle_acks(6);  // No second ack after a held strobe

        for (int i = 0; i < 40; i++) begin
            code = $unsigned($random(seed)) % 14;
            for (int l = 0; l < lanes; l++) begin
                a[l] = $random(seed);
                b[l] = $random(seed);
                pick = $random(seed);
                if (pick[1:0] == 2'd0) begin
                    b[l] = a[l];  // Equal operands now and then
                end
                exp_res[l] = lane_result(code, a[l], b[l]);
            end
            exp_cmp = compare_flag(code, a[0], b[0]);
            run_request($sformatf("rand_%0d", i), code, a, b, exp_res, exp_cmp);
        end
        count_idle_acks(4);

        assert_fails = dut.u_checker.assert_errors;
        $display("Checks: %0d, value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, value_errors, timeout_errors, assert_fails);
        if (value_errors == 0 && timeout_errors == 0 && assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* valu_top.f */
design/valu_pkg.sv
design/valu_lane.sv
design/valu_decode.sv
design/valu_execute.sv
design/valu_writeback.sv
design/valu_top.sv
dv/valu_checker.sv
dv/valu_tb.sv
